// ==== test/core_data_stim.txt ====
# port addr we be wdata exp_rdata exp_err (hex)
# port 0 core, 1 slave, 2 core half of a contested pair, 3 its slave half
0 00000010 1 f 11223344 00000000 0
0 00000010 1 6 aabbccdd 00000000 0
0 00000010 0 0 00000000 11bbcc44 0
1 00000100 1 f cafef00d 00000000 0
0 00000100 0 0 00000000 cafef00d 0
0 00000104 1 f 0badbeef 00000000 0
1 00000104 0 0 00000000 0badbeef 0
1 00000104 1 3 00001234 00000000 0
0 00000104 0 0 00000000 0bad1234 0
0 40000000 1 f deadbeef 00000000 0
0 40000004 1 c 12340000 00000000 0
0 40000000 0 0 00000000 deadbeef 0
0 40000004 0 0 00000000 1234fffb 0
0 4ffffff0 0 0 00000000 b000000f 0
0 40000000 0 0 00000000 deadbeef 0
0 20000000 1 f 55555555 00000000 1
0 00000010 0 0 00000000 11bbcc44 0
0 00002000 0 0 00000000 00000000 1
0 3fffffff 0 0 00000000 00000000 1
0 00000010 0 0 00000000 11bbcc44 0
2 00000200 1 f 00000001 00000000 0
3 00000204 1 f 00000002 00000000 0
2 00000208 1 f 00000003 00000000 0
3 0000020c 1 f 00000004 00000000 0
2 00000200 0 0 00000000 00000001 0
3 00000204 0 0 00000000 00000002 0
2 0000020c 0 0 00000000 00000004 0
3 00000208 0 0 00000000 00000003 0
0 00000200 0 0 00000000 00000001 0
1 00000208 0 0 00000000 00000003 0

// ==== vlog.f ====
source/core_data_pkg.sv
source/data_addr_decoder.sv
source/sram_arbiter.sv
source/data_sram.sv
source/core_data_top.sv
test/tb_core_data_top.sv

// ==== test/tb_core_data_top.sv ====
`timescale 1ns/1ps

module tb_core_data_top;

    localparam int TIMEOUT = 64;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
        logic        rd;
        logic        fixed_lat;
        logic [31:0] gcyc;
    } core_exp_t;

    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    core_data_pkg::data_req_t core_req;
    core_data_pkg::data_rsp_t core_rsp;
    core_data_pkg::data_req_t ext_m_req;
    core_data_pkg::data_rsp_t ext_m_rsp;
    core_data_pkg::data_req_t ext_s_req;
    core_data_pkg::data_rsp_t ext_s_rsp;

    int unsigned cyc = 0;
    core_exp_t core_q [$];
    core_data_pkg::owner_e next_win = core_data_pkg::OWN_CORE;

    // External master model state
    logic [31:0] ext_mem [logic [31:0]];
    logic [31:0] rsp_data [$];
    int unsigned rsp_due [$];
    int unsigned last_due = 0;
    int          stall = 0;
    logic        ext_ready = 1'b0;
    logic        ext_rvalid = 1'b0;
    logic [31:0] ext_rdata = '0;

    core_data_top u_core_data_top (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .core_req_i  ( core_req  ),
        .core_rsp_o  ( core_rsp  ),
        .ext_m_req_o ( ext_m_req ),
        .ext_m_rsp_i ( ext_m_rsp ),
        .ext_s_req_i ( ext_s_req ),
        .ext_s_rsp_o ( ext_s_rsp )
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc = cyc + 1;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input core_data_pkg::data_rsp_t act, input logic [31:0] exp_rdata,
                             input logic exp_err, input logic rd, input string name);
        if (act.err !== exp_err) begin
            $display("Fail at %0t: %s.err expected %b, got %b", $time, name, exp_err, act.err);
            stop_run("Response error flag mismatch");
        end
        if (rd && act.rdata !== exp_rdata) begin
            $display("Fail at %0t: %s.rdata expected %h, got %h", $time, name, exp_rdata,
                     act.rdata);
            stop_run("Read data mismatch");
        end
    endtask

    task automatic check_req(input core_data_pkg::data_req_t act,
                             input core_data_pkg::data_req_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: ext_m_req_o expected %h, got %h", $time, exp, act);
            stop_run("Master port request mismatch");
        end
    endtask

    task automatic check_owner(input core_data_pkg::owner_e exp,
                               input core_data_pkg::owner_e act);
        if (act !== exp) begin
            $display("Fail at %0t: arbiter winner expected %s, got %s", $time, exp.name(),
                     act.name());
            stop_run("Round-robin order broken");
        end
    endtask

    //////////////////////////////
    // External master responder
    //////////////////////////////

    always_comb begin
        ext_m_rsp.gnt    = ext_m_req.req && ext_ready;
        ext_m_rsp.rvalid = ext_rvalid;
        ext_m_rsp.rdata  = ext_rdata;
        ext_m_rsp.err    = 1'b0;
    end

    always @(negedge clk_i) begin
        logic [31:0] word;
        int unsigned due;
        if (rst_n_i && ext_m_req.req && ext_m_rsp.gnt) begin
            // Unwritten words read back as the inverted address
            word = ext_mem.exists(ext_m_req.addr) ? ext_mem[ext_m_req.addr] : ~ext_m_req.addr;
            if (ext_m_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (ext_m_req.be[b]) begin
                        word[b*8 +: 8] = ext_m_req.wdata[b*8 +: 8];
                    end
                end
                ext_mem[ext_m_req.addr] = word;
            end
            due = cyc + 1 + ($urandom % 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_data.push_back(word);
            rsp_due.push_back(due);
            stall = 0;
        end else if (ext_m_req.req) begin
            stall = stall + 1;
        end
    end

    always @(posedge clk_i) begin
        #1;
        ext_ready = (stall >= 2) || ($urandom % 2 == 0);
        if (rsp_due.size() != 0 && rsp_due[0] == cyc) begin
            ext_rvalid = 1'b1;
            ext_rdata  = rsp_data.pop_front();
            void'(rsp_due.pop_front());
        end else begin
            ext_rvalid = 1'b0;
        end
    end

    //////////////////////////////
    // Core port
    //////////////////////////////

    // In-order response checker for the core port
    always @(negedge clk_i) begin
        core_exp_t e;
        if (rst_n_i && core_rsp.rvalid) begin
            if (core_q.size() == 0) begin
                stop_run("Core rvalid arrived with no request outstanding");
            end
            e = core_q.pop_front();
            if (e.fixed_lat && cyc != e.gcyc + 1) begin
                stop_run("Core rvalid did not follow its grant by one cycle");
            end
            check_rsp(core_rsp, e.rdata, e.err, e.rd, "core_rsp_o");
        end
    end

    task automatic issue_core(input core_data_pkg::data_req_t req, input logic [31:0] exp_rd,
                              input logic exp_err);
        core_data_pkg::data_req_t idle;
        core_exp_t e;
        logic got;
        int n;
        got = 1'b0;
        n = 0;
        core_req = req;
        while (!got) begin
            @(negedge clk_i);
            if (core_rsp.gnt) begin
                got = 1'b1;
                idle = req;
                idle.req = 1'b0;
                if (req.addr >= core_data_pkg::EXT_BASE && req.addr <= core_data_pkg::EXT_END) begin
                    check_req(ext_m_req, req);
                end else begin
                    check_req(ext_m_req, idle);
                end
                e.rdata = exp_rd;
                e.err = exp_err;
                e.rd = !req.we || exp_err;
                e.fixed_lat = !(req.addr >= core_data_pkg::EXT_BASE &&
                                req.addr <= core_data_pkg::EXT_END);
                e.gcyc = cyc;
                core_q.push_back(e);
            end else if (++n > TIMEOUT) begin
                stop_run("Timeout waiting for core gnt");
            end
            @(posedge clk_i);
            #1;
        end
        core_req.req = 1'b0;
    endtask

    task automatic drain_core();
        int n;
        n = 0;
        while (core_q.size() != 0) begin
            if (++n > TIMEOUT) begin
                stop_run("Timeout waiting for core rvalid");
            end
            @(posedge clk_i);
            #1;
        end
    endtask

    //////////////////////////////
    // Slave port
    //////////////////////////////

    task automatic run_slave(input core_data_pkg::data_req_t req, input logic [31:0] exp_rd,
                             input logic exp_err);
        logic done;
        int n;
        done = 1'b0;
        n = 0;
        ext_s_req = req;
        while (!done) begin
            @(negedge clk_i);
            done = ext_s_rsp.gnt;
            if (!done && ++n > TIMEOUT) begin
                stop_run("Timeout waiting for slave gnt");
            end
            @(posedge clk_i);
            #1;
        end
        ext_s_req.req = 1'b0;
        done = 1'b0;
        n = 0;
        while (!done) begin
            @(negedge clk_i);
            done = ext_s_rsp.rvalid;
            if (done) begin
                check_rsp(ext_s_rsp, exp_rd, exp_err, !req.we, "ext_s_rsp_o");
            end else if (++n > TIMEOUT) begin
                stop_run("Timeout waiting for slave rvalid");
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_first_win();
        core_data_pkg::owner_e act;
        @(negedge clk_i);
        if (!core_rsp.gnt && !ext_s_rsp.gnt) begin
            stop_run("Neither side granted in a contested cycle");
        end
        act = core_rsp.gnt ? core_data_pkg::OWN_CORE : core_data_pkg::OWN_EXT;
        check_owner(next_win, act);
        next_win = (act == core_data_pkg::OWN_CORE) ? core_data_pkg::OWN_EXT
                                                    : core_data_pkg::OWN_CORE;
    endtask

    //////////////////////////////
    // Stimulus file
    //////////////////////////////

    task automatic get_entry(input int fd, output bit found, output logic [31:0] port,
                             output core_data_pkg::data_req_t req, output logic [31:0] exp_rd,
                             output logic exp_err);
        string line;
        logic [31:0] addr, we, be, wdata, err;
        int cnt;
        found = 0;
        while (!found && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h", port, addr, we, be, wdata,
                              exp_rd, err);
                if (cnt == 7) begin
                    found = 1;
                    req.req = 1'b1;
                    req.addr = addr;
                    req.we = we[0];
                    req.be = be[3:0];
                    req.wdata = wdata;
                    exp_err = err[0];
                end
            end
        end
    endtask

    initial begin
        int fd;
        bit found;
        bit found2;
        logic [31:0] port, port2, exp_rd, exp_rd2;
        logic exp_err, exp_err2;
        core_data_pkg::data_req_t req, req2;
        void'($urandom(32'h13b3_2cae));
        core_req = '0;
        ext_s_req = '0;
        fd = $fopen("test/core_data_stim.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open the stimulus file");
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        get_entry(fd, found, port, req, exp_rd, exp_err);
        while (found) begin
            case (port)
                0: issue_core(req, exp_rd, exp_err);
                1: begin
                    drain_core();
                    run_slave(req, exp_rd, exp_err);
                end
                2: begin
                    // Contested pair, the slave half is on the next line
                    get_entry(fd, found2, port2, req2, exp_rd2, exp_err2);
                    if (!found2 || port2 != 3) begin
                        stop_run("Contested core entry without its slave partner");
                    end
                    drain_core();
                    fork
                        issue_core(req, exp_rd, exp_err);
                        run_slave(req2, exp_rd2, exp_err2);
                        check_first_win();
                    join
                end
                default: stop_run("Unknown port code in the stimulus file");
            endcase
            get_entry(fd, found, port, req, exp_rd, exp_err);
        end
        drain_core();
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== source/core_data_top.sv ====
`timescale 1ns/1ps

module core_data_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Core data port
    input  core_data_pkg::data_req_t core_req_i,
    output core_data_pkg::data_rsp_t core_rsp_o,

    // Outgoing master port for the external region
    output core_data_pkg::data_req_t ext_m_req_o,
    input  core_data_pkg::data_rsp_t ext_m_rsp_i,

    // Incoming slave port into the data SRAM
    input  core_data_pkg::data_req_t ext_s_req_i,
    output core_data_pkg::data_rsp_t ext_s_rsp_o
);

    //////////////////////////////
    // Internal links
    //////////////////////////////

    // Decoder to arbiter, core side of the SRAM
    core_data_pkg::data_req_t dec_sram_req;
    core_data_pkg::data_rsp_t dec_sram_rsp;

    // Arbiter to memory
    core_data_pkg::data_req_t mem_req;
    core_data_pkg::data_rsp_t mem_rsp;

    //////////////////////////////
    // Instances
    //////////////////////////////

    data_addr_decoder u_data_addr_decoder (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .core_req_i ( core_req_i   ),
        .core_rsp_o ( core_rsp_o   ),
        .sram_req_o ( dec_sram_req ),
        .sram_rsp_i ( dec_sram_rsp ),
        .ext_req_o  ( ext_m_req_o  ),
        .ext_rsp_i  ( ext_m_rsp_i  )
    );

    // Core and slave port share the one SRAM
    sram_arbiter u_sram_arbiter (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .core_req_i ( dec_sram_req ),
        .core_rsp_o ( dec_sram_rsp ),
        .ext_req_i  ( ext_s_req_i  ),
        .ext_rsp_o  ( ext_s_rsp_o  ),
        .mem_req_o  ( mem_req      ),
        .mem_rsp_i  ( mem_rsp      )
    );

    data_sram u_data_sram (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .req_i   ( mem_req ),
        .rsp_o   ( mem_rsp )
    );

endmodule

// ==== source/data_sram.sv ====
`timescale 1ns/1ps

module data_sram (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  core_data_pkg::data_req_t req_i,
    output core_data_pkg::data_rsp_t rsp_o
);

    logic [core_data_pkg::DATA_W-1:0] mem [core_data_pkg::SRAM_WORDS];

    logic [core_data_pkg::SRAM_IDX_W-1:0] word_idx;
    logic [core_data_pkg::DATA_W-1:0]     rdata_q;
    logic                                 rvalid_q;

    // Word index sits right above the byte offset
    assign word_idx = req_i.addr[core_data_pkg::BYTE_OFF_W +: core_data_pkg::SRAM_IDX_W];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            if (req_i.we) begin
                for (int b = 0; b < core_data_pkg::BE_W; b++) begin
                    if (req_i.be[b]) begin
                        mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[word_idx];
            end
        end
    end

    // One response per access, writes included
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
        end
    end

    //////////////////////////////
    // Response
    //////////////////////////////

    // Always ready, so the grant is the request itself
    always_comb begin
        rsp_o.gnt    = req_i.req;
        rsp_o.rvalid = rvalid_q;
        rsp_o.rdata  = rdata_q;
        rsp_o.err    = 1'b0;
    end

    // A full-word write is seen by a read of the same word right after it
    a_read_after_write : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (req_i.req && !req_i.we && word_idx == $past(word_idx) &&
         $past(req_i.req && req_i.we && req_i.be == '1))
        |=> (rsp_o.rdata == $past(req_i.wdata, 2))
    ) else $error("data_sram: read after a full-word write returned stale data");

endmodule

// ==== source/sram_arbiter.sv ====
`timescale 1ns/1ps

module sram_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  core_data_pkg::data_req_t core_req_i,
    output core_data_pkg::data_rsp_t core_rsp_o,
    input  core_data_pkg::data_req_t ext_req_i,
    output core_data_pkg::data_rsp_t ext_rsp_o,
    output core_data_pkg::data_req_t mem_req_o,
    input  core_data_pkg::data_rsp_t mem_rsp_i
);

    logic                  contested;
    core_data_pkg::owner_e sel;
    core_data_pkg::owner_e last_win_q;
    core_data_pkg::owner_e owner_q;

    //////////////////////////////
    // Owner selection
    //////////////////////////////

    assign contested = core_req_i.req && ext_req_i.req;

    // On conflict the side that lost last time goes first
    always_comb begin
        if (contested) begin
            if (last_win_q == core_data_pkg::OWN_CORE) begin
                sel = core_data_pkg::OWN_EXT;
            end else begin
                sel = core_data_pkg::OWN_CORE;
            end
        end else if (ext_req_i.req) begin
            sel = core_data_pkg::OWN_EXT;
        end else begin
            sel = core_data_pkg::OWN_CORE;
        end
    end

    // Starts as if ext won, so the core takes the first conflict
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_win_q <= core_data_pkg::OWN_EXT;
        end else if (contested && mem_rsp_i.gnt) begin
            last_win_q <= sel;
        end
    end

    // Remember who got the grant so the response finds its way back
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_q <= core_data_pkg::OWN_CORE;
        end else if (mem_rsp_i.gnt) begin
            owner_q <= sel;
        end
    end

    //////////////////////////////
    // Request and response mux
    //////////////////////////////

    assign mem_req_o = (sel == core_data_pkg::OWN_EXT) ? ext_req_i : core_req_i;

    always_comb begin
        core_rsp_o = '0;
        ext_rsp_o  = '0;

        // Loser just sees gnt low and holds
        core_rsp_o.gnt = mem_rsp_i.gnt && (sel == core_data_pkg::OWN_CORE);
        ext_rsp_o.gnt  = mem_rsp_i.gnt && (sel == core_data_pkg::OWN_EXT);

        if (owner_q == core_data_pkg::OWN_CORE) begin
            core_rsp_o.rvalid = mem_rsp_i.rvalid;
            core_rsp_o.rdata  = mem_rsp_i.rdata;
            core_rsp_o.err    = mem_rsp_i.err;
        end else begin
            ext_rsp_o.rvalid = mem_rsp_i.rvalid;
            ext_rsp_o.rdata  = mem_rsp_i.rdata;
            ext_rsp_o.err    = mem_rsp_i.err;
        end
    end

    // Owner steering needs the memory to answer one cycle after each grant
    a_rsp_follows_grant : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_i.rvalid |-> $past(mem_rsp_i.gnt)
    ) else $error("sram_arbiter: memory rvalid without a grant one cycle earlier");

endmodule

// ==== source/data_addr_decoder.sv ====
`timescale 1ns/1ps

module data_addr_decoder (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  core_data_pkg::data_req_t core_req_i,
    output core_data_pkg::data_rsp_t core_rsp_o,
    output core_data_pkg::data_req_t sram_req_o,
    input  core_data_pkg::data_rsp_t sram_rsp_i,
    output core_data_pkg::data_req_t ext_req_o,
    input  core_data_pkg::data_rsp_t ext_rsp_i
);

    core_data_pkg::target_e              tgt;
    core_data_pkg::target_e              pend_tgt_q;
    logic [core_data_pkg::OUTST_W-1:0]   out_cnt_q;
    logic                                can_issue;
    logic                                issue;
    logic                                done;
    logic                                err_valid_q;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    always_comb begin
        if (core_req_i.addr >= core_data_pkg::SRAM_BASE &&
            core_req_i.addr <= core_data_pkg::SRAM_END) begin
            tgt = core_data_pkg::TGT_SRAM;
        end else if (core_req_i.addr >= core_data_pkg::EXT_BASE &&
                     core_req_i.addr <= core_data_pkg::EXT_END) begin
            tgt = core_data_pkg::TGT_EXT;
        end else begin
            tgt = core_data_pkg::TGT_NONE;
        end
    end

    // No target switch while older responses are still due
    assign can_issue = (out_cnt_q == '0) ||
                       (tgt == pend_tgt_q && out_cnt_q < core_data_pkg::MAX_OUTSTANDING);

    always_comb begin
        sram_req_o     = core_req_i;
        sram_req_o.req = core_req_i.req && can_issue && (tgt == core_data_pkg::TGT_SRAM);
        ext_req_o      = core_req_i;
        ext_req_o.req  = core_req_i.req && can_issue && (tgt == core_data_pkg::TGT_EXT);
    end

    //////////////////////////////
    // Response routing
    //////////////////////////////

    always_comb begin
        core_rsp_o = '0;
        case (tgt)
            core_data_pkg::TGT_SRAM: core_rsp_o.gnt = sram_rsp_i.gnt;
            core_data_pkg::TGT_EXT:  core_rsp_o.gnt = ext_rsp_i.gnt && ext_req_o.req;
            default:                 core_rsp_o.gnt = core_req_i.req && can_issue;
        endcase

        // Responses follow the target recorded at grant, not the live address
        case (pend_tgt_q)
            core_data_pkg::TGT_SRAM: begin
                core_rsp_o.rvalid = sram_rsp_i.rvalid;
                core_rsp_o.rdata  = sram_rsp_i.rdata;
                core_rsp_o.err    = sram_rsp_i.err;
            end
            core_data_pkg::TGT_EXT: begin
                core_rsp_o.rvalid = ext_rsp_i.rvalid;
                core_rsp_o.rdata  = ext_rsp_i.rdata;
            end
            default: begin
                core_rsp_o.rvalid = err_valid_q;
                core_rsp_o.err    = err_valid_q;
            end
        endcase
    end

    assign issue = core_rsp_o.gnt;
    assign done  = core_rsp_o.rvalid;

    //////////////////////////////
    // Outstanding tracking
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_cnt_q   <= '0;
            pend_tgt_q  <= core_data_pkg::TGT_SRAM;
            err_valid_q <= 1'b0;
        end else begin
            case ({issue, done})
                2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
                2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
                default: out_cnt_q <= out_cnt_q;
            endcase
            if (issue) begin
                pend_tgt_q <= tgt;
            end
            // Unmapped access answers one cycle after its grant
            err_valid_q <= issue && (tgt == core_data_pkg::TGT_NONE);
        end
    end

    a_rvalid_needs_pending : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        core_rsp_o.rvalid |-> (out_cnt_q != '0)
    ) else $error("data_addr_decoder: core rvalid with nothing outstanding");

endmodule

// ==== source/core_data_pkg.sv ====
package core_data_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // Byte offset bits below the word index
    localparam int unsigned BYTE_OFF_W = $clog2(BE_W);

    //////////////////////////////
    // Data memory geometry
    //////////////////////////////

    localparam int unsigned SRAM_SIZE_KB = 8;
    localparam int unsigned SRAM_WORDS   = (SRAM_SIZE_KB * 1024) / BE_W;
    localparam int unsigned SRAM_IDX_W   = $clog2(SRAM_WORDS);

    //////////////////////////////
    // Address map
    //////////////////////////////

    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] SRAM_END  = SRAM_BASE + (SRAM_SIZE_KB * 1024) - 1;

    // Everything here goes out through the master port
    localparam logic [ADDR_W-1:0] EXT_BASE  = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] EXT_END   = 32'h4FFF_FFFF;

    // Granted requests one target may hold before answering
    localparam int unsigned MAX_OUTSTANDING = 2;
    localparam int unsigned OUTST_W         = $clog2(MAX_OUTSTANDING + 1);

    //////////////////////////////
    // Port payloads
    //////////////////////////////

    // Request side, held stable until gnt
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } data_req_t;

    // Response side, gnt in the request cycle and one rvalid per grant
    typedef struct packed {
        logic              gnt;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic              err;
    } data_rsp_t;

    // Decode result of a core address
    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_EXT,
        TGT_NONE
    } target_e;

    // Who holds the SRAM in a given cycle
    typedef enum logic {
        OWN_CORE,
        OWN_EXT
    } owner_e;

endpackage
